//--- ifu.f
src/ifu_pkg.sv
src/ifu_pc_gen.sv
src/ifu_bpred.sv
src/ifu_axi_fetch.sv
src/ifu_pipe.sv
src/ifu.sv
sim/ifu_checker.sv
sim/ifu_assertions.sv
sim/tb_ifu.sv

//--- Bender.yml
package:
  name: ifu

sources:
  - src/ifu_pkg.sv
  - src/ifu_pc_gen.sv
  - src/ifu_bpred.sv
  - src/ifu_axi_fetch.sv
  - src/ifu_pipe.sv
  - src/ifu.sv
  - target: simulation
    files:
      - sim/ifu_checker.sv
      - sim/ifu_assertions.sv
      - sim/tb_ifu.sv

//--- sim/tb_ifu.sv
// IFU testbench
// scenario table of redirects, branch words and error addresses, an AXI
// memory with random latency and random decode back-pressure
`timescale 1ns/1ps

module tb_ifu;

    localparam int ROWS    = 6;
    localparam int TIMEOUT = 3000;   // cycles per wait
    localparam int QUIET   = 20;     // window with no pairs expected

    typedef struct packed {
        logic [31:0] redir;          // 0 = keep current stream
        logic [31:0] b0a, b0w, b1a, b1w;
        logic [31:0] err;            // 0 = no error block
        logic [31:0] pairs;
    } row_t;

    logic        clk = 1'b0;
    logic        rst_n_i, redirect_valid_i, id_ready_i;
    logic [31:0] redirect_addr_i;
    logic        m_axi_arready_i, m_axi_rvalid_i;
    logic [63:0] m_axi_rdata_i;
    logic [1:0]  m_axi_rresp_i;
    logic [31:0] inst1_o, inst1_addr_o, inst2_o, inst2_addr_o, m_axi_araddr_o;
    logic        inst1_valid_o, inst1_pred_o, inst2_valid_o, inst2_pred_o;
    logic        fetch_valid_o, pc_misaligned_o, read_err_o, m_axi_arvalid_o, m_axi_rready_o;
    logic [63:0] br_addr, br_word;
    logic [31:0] err_addr, rng, paddr;
    logic [1:0]  lat;
    logic        pend, abort;
    int          chk_errs, pairs, tb_errs, timeouts, target;
    row_t        table_q [ROWS];

    ifu dut_i (.*);

    ifu_checker chk_i (
        .clk(clk), .rst_n_i(rst_n_i), .redirect_valid_i(redirect_valid_i),
        .redirect_addr_i(redirect_addr_i), .id_ready_i(id_ready_i),
        .fetch_valid_i(fetch_valid_o), .inst1_i(inst1_o), .inst1_addr_i(inst1_addr_o),
        .inst1_valid_i(inst1_valid_o), .inst1_pred_i(inst1_pred_o), .inst2_i(inst2_o),
        .inst2_addr_i(inst2_addr_o), .inst2_valid_i(inst2_valid_o),
        .inst2_pred_i(inst2_pred_o), .br_addr_i(br_addr), .br_word_i(br_word),
        .err_cnt_o(chk_errs), .pair_cnt_o(pairs)
    );

    always #50 clk = ~clk;

    function automatic logic [31:0] xorshift(input logic [31:0] x);
        x = x ^ (x << 13);
        x = x ^ (x >> 17);
        return x ^ (x << 5);
    endfunction

    function automatic logic [31:0] word_at(input logic [31:0] a);
        logic [11:0] imm;
        imm = a[11:0] ^ a[23:12] ^ {4'b0000, a[31:24]};
        if (br_addr[31:0] != 0 && a == br_addr[31:0]) return br_word[31:0];
        if (br_addr[63:32] != 0 && a == br_addr[63:32]) return br_word[63:32];
        return {imm, 5'd1, 3'b000, 5'd1, 7'b0010011};
    endfunction

    // AXI slave and decode ready, one random draw per cycle
    always @(posedge clk) begin
        if (!rst_n_i) begin
            id_ready_i <= 1'b0;
            m_axi_arready_i <= 1'b0;
            m_axi_rvalid_i <= 1'b0;
            pend = 1'b0;
        end else begin
            rng = xorshift(rng);
            id_ready_i <= rng[0] | rng[1];
            m_axi_arready_i <= rng[2] | rng[3];
            if (m_axi_rvalid_i && m_axi_rready_o) m_axi_rvalid_i <= 1'b0;
            if (m_axi_arvalid_o && m_axi_arready_i) begin
                pend  = 1'b1;
                paddr = m_axi_araddr_o;
                lat   = rng[5:4];                    // 1 to 4 cycles
            end else if (pend && lat == 0) begin
                m_axi_rvalid_i <= 1'b1;
                m_axi_rdata_i  <= {word_at(paddr + 4), word_at(paddr)};
                m_axi_rresp_i  <= (err_addr != 0 && paddr == err_addr) ? 2'b10 : 2'b00;
                pend = 1'b0;
            end else if (pend) begin
                lat = lat - 1;
            end
        end
    end

    task automatic redirect(input row_t row);
        @(posedge clk);
        redirect_valid_i <= 1'b1;
        redirect_addr_i  <= row.redir;
        @(posedge clk);
        redirect_valid_i <= 1'b0;
        br_addr  <= {row.b1a, row.b0a};     // new image once the old pair is gone
        br_word  <= {row.b1w, row.b0w};
        err_addr <= row.err;
        @(negedge clk);
        if (pc_misaligned_o !== (|row.redir[1:0]) || read_err_o !== 1'b0) begin
            tb_errs++;
            $display("ERR %0t: status after redirect to %h wrong", $time, row.redir);
        end
    endtask

    task automatic wait_pairs(input int n);
        int t;
        for (t = 0; t < TIMEOUT && pairs < n && !abort; t++) @(negedge clk);
        if (pairs < n && !abort) begin
            $display("timeout: only %0d of %0d pairs arrived", pairs, n);
            timeouts++;
            abort = 1'b1;
        end
    endtask

    task automatic wait_read_err();
        int t;
        for (t = 0; t < TIMEOUT && !read_err_o && !abort; t++) @(negedge clk);
        if (!read_err_o && !abort) begin
            $display("timeout: the read error was never flagged");
            timeouts++;
            abort = 1'b1;
        end
    endtask

    // fetch must stay stopped for a while
    task automatic check_quiet(input string why);
        int t;
        int start;
        start = pairs;
        for (t = 0; t < QUIET; t++) @(negedge clk);
        if (pairs != start) begin
            tb_errs++;
            $display("ERR %0t: %0d pairs arrived after %s", $time, pairs - start, why);
        end
    endtask

    initial begin
        int t;
        int asrt_errs;
        table_q[0] = '{0, 0, 0, 0, 0, 0, 6};
        table_q[1] = '{32'h1100, 32'h1104, 32'h0000_0463, 32'h1110, 32'hfe00_0ee3, 0, 8};
        table_q[2] = '{32'h1204, 32'h120c, 32'h0200_006f, 32'h1230, 32'hff9f_f06f, 0, 10};
        table_q[3] = '{32'h1302, 0, 0, 0, 0, 0, 0};
        table_q[4] = '{32'h1400, 0, 0, 0, 0, 32'h1420, 0};
        table_q[5] = '{32'h1500, 0, 0, 0, 0, 0, 40};
        rng = 32'h56c3b3e7;
        rst_n_i = 1'b0;
        redirect_valid_i = 1'b0;
        redirect_addr_i = '0;
        id_ready_i = 1'b0;
        m_axi_arready_i = 1'b0;
        m_axi_rvalid_i = 1'b0;
        m_axi_rdata_i = '0;
        m_axi_rresp_i = 2'b00;
        br_addr = '0;
        br_word = '0;
        err_addr = '0;
        abort = 1'b0;
        tb_errs = 0;
        timeouts = 0;
        repeat (3) @(posedge clk);
        rst_n_i <= 1'b1;
        for (t = 0; t < TIMEOUT && !m_axi_arvalid_o; t++) @(negedge clk);
        if (!m_axi_arvalid_o) begin
            $display("timeout: no read request after reset");
            timeouts++;
            abort = 1'b1;
        end else if (m_axi_araddr_o !== 32'h0000_1000) begin
            tb_errs++;
            $display("ERR %0t: first read at %h, not the reset pc", $time, m_axi_araddr_o);
        end
        for (int r = 0; r < ROWS && !abort; r++) begin
            if (table_q[r].redir != 0) redirect(table_q[r]);
            if (table_q[r].redir[1:0] != 0) begin
                check_quiet("a misaligned redirect");
            end else if (table_q[r].err != 0) begin
                wait_read_err();
                if (!abort) check_quiet("a read error");
            end else begin
                target = pairs + table_q[r].pairs;
                wait_pairs(target);
            end
        end
        asrt_errs = dut_i.u_assert.fail_cnt;
        $display("errors: %0d checker, %0d testbench, %0d assertion; %0d timeouts, %0d pairs",
                 chk_errs, tb_errs, asrt_errs, timeouts, pairs);
        if (chk_errs == 0 && tb_errs == 0 && asrt_errs == 0 && timeouts == 0) begin
            $display("test passed");
        end else begin
            $display("test failed");
        end
        $finish;
    end

endmodule

//--- sim/ifu_assertions.sv
// IFU handshake assertions
// AR and decode stability, no new AR while fetch is halted,
// no unknown control outputs out of reset
`timescale 1ns/1ps

module ifu_assertions (
    input logic         clk,
    input logic         rst_n_i,
    input logic         redirect_valid_i,
    input logic         id_ready_i,
    input logic         fetch_valid_i,
    input logic [131:0] pair_i,          // every decode output but the valid
    input logic [31:0]  araddr_i,
    input logic         arvalid_i,
    input logic         arready_i,
    input logic         rready_i,
    input logic         pc_misaligned_i,
    input logic         read_err_i
);

    int fail_cnt = 0;   // assertion failures so far

    ar_stable: assert property (@(posedge clk) disable iff (!rst_n_i)
        arvalid_i && !arready_i |=> arvalid_i && $stable(araddr_i))
        else begin
            $error("AR dropped or changed before ready");
            fail_cnt++;
        end

    id_stable: assert property (@(posedge clk) disable iff (!rst_n_i)
        fetch_valid_i && !id_ready_i && !redirect_valid_i |=> fetch_valid_i && $stable(pair_i))
        else begin
            $error("decode pair changed while stalled");
            fail_cnt++;
        end

    // once AR is down while halted it stays down until a redirect
    no_ar_halted: assert property (@(posedge clk) disable iff (!rst_n_i)
        (read_err_i || pc_misaligned_i) && !arvalid_i && !redirect_valid_i |=> !arvalid_i)
        else begin
            $error("AR issued while fetch is halted");
            fail_cnt++;
        end

    no_x: assert property (@(posedge clk) disable iff (!rst_n_i)
        !$isunknown({fetch_valid_i, arvalid_i, rready_i, pc_misaligned_i, read_err_i}))
        else begin
            $error("control output unknown");
            fail_cnt++;
        end

endmodule

bind ifu ifu_assertions u_assert (
    .clk              (clk),
    .rst_n_i          (rst_n_i),
    .redirect_valid_i (redirect_valid_i),
    .id_ready_i       (id_ready_i),
    .fetch_valid_i    (fetch_valid_o),
    .pair_i           ({inst2_pred_o, inst2_valid_o, inst2_addr_o, inst2_o,
                        inst1_pred_o, inst1_valid_o, inst1_addr_o, inst1_o}),
    .araddr_i         (m_axi_araddr_o),
    .arvalid_i        (m_axi_arvalid_o),
    .arready_i        (m_axi_arready_i),
    .rready_i         (m_axi_rready_o),
    .pc_misaligned_i  (pc_misaligned_o),
    .read_err_i       (read_err_o)
);

//--- sim/ifu_checker.sv
// IFU stream checker
// replays the slot and next-PC rules over the memory image, compares
// every pair taken by decode and counts mismatches
`timescale 1ns/1ps

module ifu_checker (
    input  logic        clk,
    input  logic        rst_n_i,
    input  logic        redirect_valid_i,
    input  logic [31:0] redirect_addr_i,
    input  logic        id_ready_i,
    input  logic        fetch_valid_i,
    input  logic [31:0] inst1_i,
    input  logic [31:0] inst1_addr_i,
    input  logic        inst1_valid_i,
    input  logic        inst1_pred_i,
    input  logic [31:0] inst2_i,
    input  logic [31:0] inst2_addr_i,
    input  logic        inst2_valid_i,
    input  logic        inst2_pred_i,
    input  logic [63:0] br_addr_i,      // two branch locations, 0 = unused
    input  logic [63:0] br_word_i,
    output int          err_cnt_o,
    output int          pair_cnt_o
);

    logic [31:0] exp_pc;    // entry pc of next expected pair
    logic        halted;    // misaligned redirect seen

    // memory image: ADDI everywhere unless a branch word sits there
    function automatic logic [31:0] word_at(input logic [31:0] a);
        logic [11:0] imm;
        logic [31:0] w;
        imm = a[11:0] ^ a[23:12] ^ {4'b0000, a[31:24]};
        w   = {imm, 5'd1, 3'b000, 5'd1, 7'b0010011};     // addi x1, x1, imm
        if (br_addr_i[31:0] != 0 && a == br_addr_i[31:0]) w = br_word_i[31:0];
        if (br_addr_i[63:32] != 0 && a == br_addr_i[63:32]) w = br_word_i[63:32];
        return w;
    endfunction

    function automatic logic predicted(input logic [31:0] w);
        return (w[6:0] == 7'h6f) || (w[6:0] == 7'h63 && w[31]);   // jal, or backward b
    endfunction

    function automatic logic [31:0] offset(input logic [31:0] w);
        logic signed [31:0] off;
        if (w[6:0] == 7'h6f) off = $signed({w[31], w[19:12], w[20], w[30:21], 1'b0});
        else                 off = $signed({w[31], w[7], w[30:25], w[11:8], 1'b0});
        return off;
    endfunction

    task automatic compare(input string name, input logic [31:0] got, input logic [31:0] exp);
        if (got !== exp) begin
            err_cnt_o++;
            $display("ERR %0t: %s is %h, expected %h", $time, name, got, exp);
        end
    endtask

    always @(posedge clk or negedge rst_n_i) begin
        logic [31:0] blk;
        logic [31:0] w0;
        logic [31:0] w1;
        logic        v1;
        logic        v2;
        logic        p0;
        logic        p1;
        if (!rst_n_i) begin
            exp_pc     <= 32'h0000_1000;
            halted     <= 1'b0;
            err_cnt_o  = 0;
            pair_cnt_o = 0;
        end else begin
            if (fetch_valid_i && id_ready_i) begin
                blk = {exp_pc[31:3], 3'b000};
                w0  = word_at(blk);
                w1  = word_at(blk + 4);
                v1  = !exp_pc[2];                // odd entry skips low slot
                p0  = v1 && predicted(w0);
                v2  = !p0;
                p1  = v2 && predicted(w1);
                if (halted) begin
                    err_cnt_o++;
                    $display("ERR %0t: pair accepted while fetch is halted", $time);
                end
                compare("slot1 valid", inst1_valid_i, v1);
                compare("slot2 valid", inst2_valid_i, v2);
                if (v1) begin
                    compare("slot1 addr", inst1_addr_i, blk);
                    compare("slot1 word", inst1_i, w0);
                    compare("slot1 pred", inst1_pred_i, p0);
                end
                if (v2) begin
                    compare("slot2 addr", inst2_addr_i, blk + 4);
                    compare("slot2 word", inst2_i, w1);
                    compare("slot2 pred", inst2_pred_i, p1);
                end
                pair_cnt_o++;
                if (p0)      exp_pc <= blk + offset(w0);
                else if (p1) exp_pc <= blk + 4 + offset(w1);
                else         exp_pc <= blk + 8;
            end
            if (redirect_valid_i) begin          // overrides the advance above
                exp_pc <= redirect_addr_i;
                halted <= |redirect_addr_i[1:0];
            end
        end
    end

endmodule

//--- src/ifu.sv
// Dual-issue instruction fetch unit
// PC generator, AXI read master, static predictor and IF/ID register;
// a backend redirect flushes the pipe and any read in flight
`timescale 1ns/1ps

module ifu (
    input  logic                        clk,
    input  logic                        rst_n_i,
    // backend redirect
    input  logic                        redirect_valid_i,
    input  logic [ifu_pkg::ADDR_W-1:0]  redirect_addr_i,
    // decode side
    input  logic                        id_ready_i,
    output logic [ifu_pkg::INST_W-1:0]  inst1_o,
    output logic [ifu_pkg::ADDR_W-1:0]  inst1_addr_o,
    output logic                        inst1_valid_o,
    output logic                        inst1_pred_o,
    output logic [ifu_pkg::INST_W-1:0]  inst2_o,
    output logic [ifu_pkg::ADDR_W-1:0]  inst2_addr_o,
    output logic                        inst2_valid_o,
    output logic                        inst2_pred_o,
    output logic                        fetch_valid_o,
    // status
    output logic                        pc_misaligned_o,
    output logic                        read_err_o,
    // AXI read
    output logic [ifu_pkg::ADDR_W-1:0]  m_axi_araddr_o,
    output logic                        m_axi_arvalid_o,
    input  logic                        m_axi_arready_i,
    input  logic [ifu_pkg::BLOCK_W-1:0] m_axi_rdata_i,
    input  logic [1:0]                  m_axi_rresp_i,
    input  logic                        m_axi_rvalid_i,
    output logic                        m_axi_rready_o
);

    logic [ifu_pkg::ADDR_W-1:0]  fetch_pc;
    logic                        pc_ok;
    logic                        req_done;      // good block accepted
    logic [ifu_pkg::BLOCK_W-1:0] blk_data;
    logic [ifu_pkg::ADDR_W-1:0]  blk_pc;
    logic                        blk_valid;
    logic                        pred_taken;
    logic [ifu_pkg::ADDR_W-1:0]  pred_target;
    logic                        pred0;
    logic                        pred1;
    logic                        pipe_ready;

    ifu_pc_gen u_pc_gen (
        .clk              (clk),
        .rst_n_i          (rst_n_i),
        .redirect_valid_i (redirect_valid_i),
        .redirect_addr_i  (redirect_addr_i),
        .req_done_i       (req_done),
        .pred_taken_i     (pred_taken),
        .pred_target_i    (pred_target),
        .err_halt_i       (read_err_o),     // bus error stops fetch
        .fetch_pc_o       (fetch_pc),
        .pc_ok_o          (pc_ok),
        .pc_misaligned_o  (pc_misaligned_o)
    );

    ifu_axi_fetch u_axi_fetch (
        .clk             (clk),
        .rst_n_i         (rst_n_i),
        .fetch_pc_i      (fetch_pc),
        .pc_ok_i         (pc_ok),
        .flush_i         (redirect_valid_i),
        .pipe_ready_i    (pipe_ready),
        .req_done_o      (req_done),
        .blk_data_o      (blk_data),
        .blk_pc_o        (blk_pc),
        .blk_valid_o     (blk_valid),
        .read_err_o      (read_err_o),
        .m_axi_araddr_o  (m_axi_araddr_o),
        .m_axi_arvalid_o (m_axi_arvalid_o),
        .m_axi_arready_i (m_axi_arready_i),
        .m_axi_rdata_i   (m_axi_rdata_i),
        .m_axi_rresp_i   (m_axi_rresp_i),
        .m_axi_rvalid_i  (m_axi_rvalid_i),
        .m_axi_rready_o  (m_axi_rready_o)
    );

    ifu_bpred u_bpred (
        .blk_data_i    (blk_data),
        .blk_pc_i      (blk_pc),
        .blk_valid_i   (blk_valid),
        .pred_taken_o  (pred_taken),
        .pred_target_o (pred_target),
        .pred0_o       (pred0),
        .pred1_o       (pred1)
    );

    ifu_pipe u_pipe (
        .clk           (clk),
        .rst_n_i       (rst_n_i),
        .blk_valid_i   (blk_valid),
        .blk_data_i    (blk_data),
        .blk_pc_i      (blk_pc),
        .pred0_i       (pred0),
        .pred1_i       (pred1),
        .flush_i       (redirect_valid_i),
        .id_ready_i    (id_ready_i),
        .pipe_ready_o  (pipe_ready),
        .inst1_o       (inst1_o),
        .inst1_addr_o  (inst1_addr_o),
        .inst1_valid_o (inst1_valid_o),
        .inst1_pred_o  (inst1_pred_o),
        .inst2_o       (inst2_o),
        .inst2_addr_o  (inst2_addr_o),
        .inst2_valid_o (inst2_valid_o),
        .inst2_pred_o  (inst2_pred_o),
        .fetch_valid_o (fetch_valid_o)
    );

endmodule

//--- src/ifu_pipe.sv
// IF/ID register
// one-entry valid/ready stage toward decode; applies the slot rule,
// forms both instruction addresses and empties on a flush
`timescale 1ns/1ps

module ifu_pipe (
    input  logic                        clk,
    input  logic                        rst_n_i,
    input  logic                        blk_valid_i,
    input  logic [ifu_pkg::BLOCK_W-1:0] blk_data_i,
    input  logic [ifu_pkg::ADDR_W-1:0]  blk_pc_i,
    input  logic                        pred0_i,
    input  logic                        pred1_i,
    input  logic                        flush_i,
    input  logic                        id_ready_i,
    output logic                        pipe_ready_o,
    output logic [ifu_pkg::INST_W-1:0]  inst1_o,
    output logic [ifu_pkg::ADDR_W-1:0]  inst1_addr_o,
    output logic                        inst1_valid_o,
    output logic                        inst1_pred_o,
    output logic [ifu_pkg::INST_W-1:0]  inst2_o,
    output logic [ifu_pkg::ADDR_W-1:0]  inst2_addr_o,
    output logic                        inst2_valid_o,
    output logic                        inst2_pred_o,
    output logic                        fetch_valid_o
);

    logic                       slot1_v;
    logic                       slot2_v;
    logic [ifu_pkg::ADDR_W-1:0] blk_addr;

    assign slot1_v  = !blk_pc_i[2];                 // entered at the high word
    assign slot2_v  = !(slot1_v && pred0_i);        // squashed behind taken slot 1
    assign blk_addr = {blk_pc_i[ifu_pkg::ADDR_W-1:3], 3'b000};

    assign pipe_ready_o = !fetch_valid_o || id_ready_i;

    always_ff @(posedge clk or negedge rst_n_i) begin
        if (!rst_n_i) begin
            fetch_valid_o <= 1'b0;
            inst1_valid_o <= 1'b0;
            inst1_pred_o  <= 1'b0;
            inst2_valid_o <= 1'b0;
            inst2_pred_o  <= 1'b0;
        end else if (flush_i) begin
            fetch_valid_o <= 1'b0;                  // pair in flight never shows
        end else if (blk_valid_i) begin
            fetch_valid_o <= 1'b1;
            inst1_valid_o <= slot1_v;
            inst1_pred_o  <= slot1_v && pred0_i;
            inst2_valid_o <= slot2_v;
            inst2_pred_o  <= slot2_v && pred1_i;
        end else if (id_ready_i) begin
            fetch_valid_o <= 1'b0;                  // taken by decode
        end
    end

    always_ff @(posedge clk) begin
        if (blk_valid_i) begin
            inst1_o      <= blk_data_i[ifu_pkg::INST_W-1:0];
            inst1_addr_o <= blk_addr;
            inst2_o      <= blk_data_i[ifu_pkg::BLOCK_W-1:ifu_pkg::INST_W];
            inst2_addr_o <= blk_addr + ifu_pkg::INST_BYTES;
        end
    end

endmodule

//--- src/ifu_axi_fetch.sv
// IFU AXI read master
// one single-beat 64-bit read outstanding at a time; a flush while a read
// is in flight marks its beat stale so it is taken and dropped, and an
// error response stops fetch in FS_HALT until the next flush
`timescale 1ns/1ps

module ifu_axi_fetch (
    input  logic                        clk,
    input  logic                        rst_n_i,
    input  logic [ifu_pkg::ADDR_W-1:0]  fetch_pc_i,
    input  logic                        pc_ok_i,
    input  logic                        flush_i,
    input  logic                        pipe_ready_i,
    output logic                        req_done_o,
    output logic [ifu_pkg::BLOCK_W-1:0] blk_data_o,
    output logic [ifu_pkg::ADDR_W-1:0]  blk_pc_o,
    output logic                        blk_valid_o,
    output logic                        read_err_o,
    // AR channel
    output logic [ifu_pkg::ADDR_W-1:0]  m_axi_araddr_o,
    output logic                        m_axi_arvalid_o,
    input  logic                        m_axi_arready_i,
    // R channel
    input  logic [ifu_pkg::BLOCK_W-1:0] m_axi_rdata_i,
    input  logic [1:0]                  m_axi_rresp_i,
    input  logic                        m_axi_rvalid_i,
    output logic                        m_axi_rready_o
);

    ifu_pkg::fetch_state_e state_q;
    ifu_pkg::fetch_state_e state_d;

    logic                       stale_q;     // outstanding beat belongs to flushed stream
    logic                       ar_wait_q;   // AR shown last cycle, not yet taken
    logic [ifu_pkg::ADDR_W-1:0] ar_pc_q;     // pc held while AR waits
    logic [ifu_pkg::ADDR_W-1:0] req_pc_q;    // pc of read in flight
    logic [ifu_pkg::ADDR_W-1:0] ar_pc;       // pc behind current AR
    logic                       ar_hs;
    logic                       r_hs;
    logic                       r_live;      // beat that counts
    logic                       r_err;

    // keep AR stable once shown, even if fetch pc moves on a redirect
    assign ar_pc           = ar_wait_q ? ar_pc_q : fetch_pc_i;
    assign m_axi_araddr_o  = {ar_pc[ifu_pkg::ADDR_W-1:3], 3'b000};
    assign m_axi_arvalid_o = (state_q == ifu_pkg::FS_ADDR) && (ar_wait_q || pc_ok_i);
    assign m_axi_rready_o  = (state_q == ifu_pkg::FS_DATA) && (stale_q || pipe_ready_i);

    assign ar_hs  = m_axi_arvalid_o && m_axi_arready_i;
    assign r_hs   = m_axi_rvalid_i && m_axi_rready_o;
    assign r_live = r_hs && !stale_q && !flush_i;
    assign r_err  = r_live && (m_axi_rresp_i != 2'b00);   // SLVERR or DECERR

    assign blk_valid_o = r_live && !r_err;
    assign req_done_o  = blk_valid_o;       // pc advances only on a good block
    assign blk_data_o  = m_axi_rdata_i;
    assign blk_pc_o    = req_pc_q;

    always_comb begin
        state_d = state_q;
        case (state_q)
            ifu_pkg::FS_IDLE: begin
                if (pc_ok_i || flush_i) begin
                    state_d = ifu_pkg::FS_ADDR;
                end
            end
            ifu_pkg::FS_ADDR: begin
                if (ar_hs) begin
                    state_d = ifu_pkg::FS_DATA;
                end else if (!m_axi_arvalid_o && !flush_i) begin
                    state_d = ifu_pkg::FS_IDLE;   // pc not ok, park
                end
            end
            ifu_pkg::FS_DATA: begin
                if (r_hs) begin
                    state_d = r_err ? ifu_pkg::FS_HALT : ifu_pkg::FS_ADDR;
                end
            end
            default: begin                        // FS_HALT
                if (flush_i) begin
                    state_d = ifu_pkg::FS_ADDR;
                end
            end
        endcase
    end

    always_ff @(posedge clk or negedge rst_n_i) begin
        if (!rst_n_i) begin
            state_q    <= ifu_pkg::FS_IDLE;
            stale_q    <= 1'b0;
            ar_wait_q  <= 1'b0;
            read_err_o <= 1'b0;
        end else begin
            state_q   <= state_d;
            ar_wait_q <= m_axi_arvalid_o && !m_axi_arready_i;
            if (r_hs) begin
                stale_q <= 1'b0;                  // nothing left outstanding
            end else if (flush_i && (state_q == ifu_pkg::FS_DATA || m_axi_arvalid_o)) begin
                stale_q <= 1'b1;                  // drop the beat when it comes
            end
            if (flush_i) begin
                read_err_o <= 1'b0;
            end else if (r_err) begin
                read_err_o <= 1'b1;
            end
        end
    end

    always_ff @(posedge clk) begin
        if (m_axi_arvalid_o) begin
            ar_pc_q <= ar_pc;
        end
        if (ar_hs) begin
            req_pc_q <= ar_pc;                    // full pc, bit 2 marks odd entry
        end
    end

endmodule

//--- src/ifu_bpred.sv
// IFU static branch predictor
// decodes both slots of a returned block, predicts JAL and backward
// conditional branches taken, and picks the first predicted slot in order
`timescale 1ns/1ps

module ifu_bpred (
    input  logic [ifu_pkg::BLOCK_W-1:0] blk_data_i,
    input  logic [ifu_pkg::ADDR_W-1:0]  blk_pc_i,
    input  logic                        blk_valid_i,
    output logic                        pred_taken_o,
    output logic [ifu_pkg::ADDR_W-1:0]  pred_target_o,
    output logic                        pred0_o,
    output logic                        pred1_o
);

    logic [ifu_pkg::INST_W-1:0] inst0;
    logic [ifu_pkg::INST_W-1:0] inst1;
    logic [ifu_pkg::ADDR_W-1:0] pc0;
    logic [ifu_pkg::ADDR_W-1:0] pc1;

    // JAL always, conditional branch only with negative offset
    function automatic logic is_taken(input logic [ifu_pkg::INST_W-1:0] inst);
        logic taken;
        case (ifu_pkg::opcode_e'(inst[6:0]))
            ifu_pkg::OPC_JAL:    taken = 1'b1;
            ifu_pkg::OPC_BRANCH: taken = inst[31];   // sign of B immediate
            default:             taken = 1'b0;
        endcase
        return taken;
    endfunction

    // J immediate for JAL, B immediate otherwise
    function automatic logic [ifu_pkg::ADDR_W-1:0] imm_of(
        input logic [ifu_pkg::INST_W-1:0] inst
    );
        logic [ifu_pkg::ADDR_W-1:0] imm;
        if (inst[6:0] == ifu_pkg::OPC_JAL) begin
            imm = {{12{inst[31]}}, inst[19:12], inst[20], inst[30:21], 1'b0};
        end else begin
            imm = {{20{inst[31]}}, inst[7], inst[30:25], inst[11:8], 1'b0};
        end
        return imm;
    endfunction

    assign inst0 = blk_data_i[ifu_pkg::INST_W-1:0];                    // low word
    assign inst1 = blk_data_i[ifu_pkg::BLOCK_W-1:ifu_pkg::INST_W];     // high word
    assign pc0   = {blk_pc_i[ifu_pkg::ADDR_W-1:3], 3'b000};
    assign pc1   = pc0 + ifu_pkg::INST_BYTES;

    assign pred0_o = !blk_pc_i[2] && is_taken(inst0);   // slot 0 skipped on odd entry
    assign pred1_o = is_taken(inst1);

    assign pred_taken_o  = blk_valid_i && (pred0_o || pred1_o);
    assign pred_target_o = pred0_o ? pc0 + imm_of(inst0)     // earlier slot first
                                   : pc1 + imm_of(inst1);

endmodule

//--- src/ifu_pc_gen.sv
// IFU fetch PC generator
// holds the block PC, advances it on each accepted block (predicted target
// or next sequential block), takes backend redirects and halts on a
// misaligned redirect or a read error
`timescale 1ns/1ps

module ifu_pc_gen (
    input  logic                       clk,
    input  logic                       rst_n_i,
    input  logic                       redirect_valid_i,
    input  logic [ifu_pkg::ADDR_W-1:0] redirect_addr_i,
    input  logic                       req_done_i,
    input  logic                       pred_taken_i,
    input  logic [ifu_pkg::ADDR_W-1:0] pred_target_i,
    input  logic                       err_halt_i,
    output logic [ifu_pkg::ADDR_W-1:0] fetch_pc_o,
    output logic                       pc_ok_o,
    output logic                       pc_misaligned_o
);

    logic                       halted_q;    // fetch stopped until aligned redirect
    logic                       redir_bad;   // low two bits set
    logic [ifu_pkg::ADDR_W-1:0] seq_pc;      // next block, sequential

    assign redir_bad = |redirect_addr_i[1:0];
    assign seq_pc    = {fetch_pc_o[ifu_pkg::ADDR_W-1:3], 3'b000} + ifu_pkg::BLOCK_BYTES;
    assign pc_ok_o   = !halted_q;

    always_ff @(posedge clk or negedge rst_n_i) begin
        if (!rst_n_i) begin
            fetch_pc_o      <= ifu_pkg::RESET_PC;
            halted_q        <= 1'b0;
            pc_misaligned_o <= 1'b0;
        end else if (redirect_valid_i) begin    // backend wins over everything
            fetch_pc_o      <= redirect_addr_i;
            halted_q        <= redir_bad;       // aligned redirect also clears error halt
            pc_misaligned_o <= redir_bad;
        end else begin
            if (req_done_i) begin
                fetch_pc_o <= pred_taken_i ? pred_target_i : seq_pc;
            end
            if (err_halt_i) begin
                halted_q <= 1'b1;               // bus error, wait for redirect
            end
        end
    end

endmodule

//--- src/ifu_pkg.sv
// IFU shared definitions
// widths, reset PC, the opcodes the static predictor decodes
// and the state encoding of the AXI fetch FSM
package ifu_pkg;

    localparam int ADDR_W  = 32;   // instruction address width
    localparam int INST_W  = 32;   // one instruction
    localparam int BLOCK_W = 64;   // two instructions per fetch

    localparam logic [ADDR_W-1:0] RESET_PC    = 32'h0000_1000;  // 8-aligned boot address
    localparam logic [ADDR_W-1:0] INST_BYTES  = 32'd4;          // slot stride
    localparam logic [ADDR_W-1:0] BLOCK_BYTES = 32'd8;          // sequential block stride

    // values outside this enum are simply not branches
    typedef enum logic [6:0] {
        OPC_BRANCH = 7'b1100011,   // conditional branch, B-type
        OPC_JAL    = 7'b1101111    // direct jump, J-type
    } opcode_e;

    typedef enum logic [1:0] {
        FS_IDLE = 2'd0,   // no request
        FS_ADDR = 2'd1,   // AR valid, waiting for ready
        FS_DATA = 2'd2,   // waiting for R beat
        FS_HALT = 2'd3    // stopped on read error
    } fetch_state_e;

endpackage
